// File: src/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define DATA_WIDTH 32

// Primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_SPECIAL2 6'b011100
`define OP_SPECIAL3 6'b011111

// REGIMM rt field and SPECIAL3 sa field
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001
`define SA_SEB      5'b10000
`define SA_SEH      5'b11000

// SPECIAL function codes
`define FUNC_SLL    6'b000000
`define FUNC_SRL    6'b000010  // ROTR when bit 21 is set
`define FUNC_SRA    6'b000011
`define FUNC_SLLV   6'b000100
`define FUNC_SRLV   6'b000110  // ROTRV when bit 6 is set
`define FUNC_SRAV   6'b000111
`define FUNC_JR     6'b001000
`define FUNC_MOVZ   6'b001010
`define FUNC_MOVN   6'b001011
`define FUNC_MFHI   6'b010000
`define FUNC_MTHI   6'b010001
`define FUNC_MFLO   6'b010010
`define FUNC_MTLO   6'b010011
`define FUNC_MULT   6'b011000
`define FUNC_MULTU  6'b011001
`define FUNC_ADD    6'b100000
`define FUNC_ADDU   6'b100001
`define FUNC_SUB    6'b100010
`define FUNC_AND    6'b100100
`define FUNC_OR     6'b100101
`define FUNC_XOR    6'b100110
`define FUNC_NOR    6'b100111
`define FUNC_SLT    6'b101010
`define FUNC_SLTU   6'b101011

// SPECIAL2 and SPECIAL3 function codes
`define FUNC_MADD   6'b000000
`define FUNC_MUL    6'b000010
`define FUNC_MSUB   6'b000100
`define FUNC_SEB    6'b100000  // BSHFL, shared by SEB and SEH

`endif

// File: src/mips_pkg.sv
`include "mips_defs.svh"

package mips_pkg;

    typedef logic [`DATA_WIDTH-1:0] wordT;

    // Operation class from the main controller
    typedef enum logic [5:0] {
        ALUOP_ZERO     = 6'd0,   // SPECIAL, refined by funct
        ALUOP_ADDIU    = 6'd1,
        ALUOP_ADDI     = 6'd2,
        ALUOP_MUL      = 6'd3,   // SPECIAL2, refined by funct
        ALUOP_LUI      = 6'd4,
        ALUOP_BLTZ     = 6'd5,
        ALUOP_BEQ      = 6'd6,
        ALUOP_BNE      = 6'd7,
        ALUOP_BGTZ     = 6'd8,
        ALUOP_BLEZ     = 6'd9,
        ALUOP_BGEZ     = 6'd10,
        ALUOP_JUMP     = 6'd11,  // J, JAL, JR
        ALUOP_ANDI     = 6'd12,
        ALUOP_ORI      = 6'd13,
        ALUOP_XORI     = 6'd14,
        ALUOP_SEB      = 6'd15,
        ALUOP_SLTI     = 6'd16,
        ALUOP_SLTIU    = 6'd17,
        ALUOP_SRL      = 6'd18,
        ALUOP_ROTR     = 6'd19,
        ALUOP_SRLV     = 6'd20,
        ALUOP_SEH      = 6'd21,
        ALUOP_ROTRV    = 6'd22,
        ALUOP_SPECIAL3 = 6'd23   // Unsupported SPECIAL3 sub-op
    } aluOpE;

    // Control code seen by the ALU and HI/LO
    typedef enum logic [5:0] {
        ADD  = 6'd0,  ADDU  = 6'd1,  SUB   = 6'd2,  MUL  = 6'd3,
        MULT = 6'd4,  MULTU = 6'd5,  MADD  = 6'd6,  MSUB = 6'd7,
        BGEZ = 6'd8,  BEQ   = 6'd9,  BNE   = 6'd10, BGTZ = 6'd11,
        BLEZ = 6'd12, BLTZ  = 6'd13, JUMP  = 6'd14, SRAV = 6'd15,
        ROTRV = 6'd16,
        LUI  = 6'd17, AND   = 6'd18, OR    = 6'd19, NOR  = 6'd20,
        XOR  = 6'd21, SEH   = 6'd22, SLL   = 6'd23, SRL  = 6'd24,
        MOVN = 6'd25, MOVZ  = 6'd26, ROTR  = 6'd27, SRA  = 6'd28,
        SEB  = 6'd29, SLT   = 6'd30, SLTU  = 6'd31, MTHI = 6'd32,
        MTLO = 6'd33, MFHI  = 6'd34, MFLO  = 6'd35, SLLV = 6'd36,
        SRLV = 6'd37
    } aluCtrlE;

endpackage

// File: src/Controller.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module Controller (
    input  logic [31:0]     instr,
    output mips_pkg::aluOpE aluOp,
    output logic            aluSrc,    // Immediate as second operand
    output logic            zeroExt,   // Zero-extend the immediate
    output logic            regWrite,
    input  logic            moveOk     // MOVZ/MOVN condition from the ALU
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;
    logic [4:0] sa;
    logic       writeEn;   // Write intent before the move condition

    assign opcode = instr[31:26];
    assign rt     = instr[20:16];
    assign sa     = instr[10:6];
    assign funct  = instr[5:0];

    always_comb begin
        aluOp   = ALUOP_ADDI;   // Unknown opcode falls back to ADD
        aluSrc  = 1'b0;
        zeroExt = 1'b0;
        writeEn = 1'b0;
        case (opcode)
            `OP_SPECIAL: begin
                aluOp = ALUOP_ZERO;
                case (funct)
                    `FUNC_SRL: begin
                        if (instr[21]) begin
                            aluOp = ALUOP_ROTR;
                        end else begin
                            aluOp = ALUOP_SRL;
                        end
                        writeEn = 1'b1;
                    end
                    `FUNC_SRLV: begin
                        if (instr[6]) begin
                            aluOp = ALUOP_ROTRV;
                        end else begin
                            aluOp = ALUOP_SRLV;
                        end
                        writeEn = 1'b1;
                    end
                    `FUNC_JR: aluOp = ALUOP_JUMP;
                    `FUNC_SLL, `FUNC_SRA, `FUNC_SLLV, `FUNC_SRAV,
                    `FUNC_MOVZ, `FUNC_MOVN, `FUNC_MFHI, `FUNC_MFLO,
                    `FUNC_ADD, `FUNC_ADDU, `FUNC_SUB, `FUNC_AND,
                    `FUNC_OR, `FUNC_XOR, `FUNC_NOR, `FUNC_SLT,
                    `FUNC_SLTU: writeEn = 1'b1;
                    default: writeEn = 1'b0;   // HI/LO writers and unknown functs
                endcase
            end
            `OP_SPECIAL2: begin
                aluOp   = ALUOP_MUL;
                writeEn = (funct == `FUNC_MUL);   // MADD/MSUB only touch HI/LO
            end
            `OP_SPECIAL3: begin
                if (funct == `FUNC_SEB && sa == `SA_SEB) begin
                    aluOp   = ALUOP_SEB;
                    writeEn = 1'b1;
                end else if (funct == `FUNC_SEB && sa == `SA_SEH) begin
                    aluOp   = ALUOP_SEH;
                    writeEn = 1'b1;
                end else begin
                    aluOp = ALUOP_SPECIAL3;
                end
            end
            `OP_REGIMM: begin
                if (rt == `RT_BGEZ) begin
                    aluOp = ALUOP_BGEZ;
                end else if (rt == `RT_BLTZ) begin
                    aluOp = ALUOP_BLTZ;
                end
            end
            `OP_J: aluOp = ALUOP_JUMP;
            `OP_JAL: begin
                aluOp   = ALUOP_JUMP;
                writeEn = 1'b1;   // Link register write
            end
            `OP_BEQ:  aluOp = ALUOP_BEQ;
            `OP_BNE:  aluOp = ALUOP_BNE;
            `OP_BLEZ: aluOp = ALUOP_BLEZ;
            `OP_BGTZ: aluOp = ALUOP_BGTZ;
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_LUI: begin
                case (opcode)
                    `OP_ADDI:  aluOp = ALUOP_ADDI;
                    `OP_ADDIU: aluOp = ALUOP_ADDIU;
                    `OP_SLTI:  aluOp = ALUOP_SLTI;
                    `OP_SLTIU: aluOp = ALUOP_SLTIU;
                    default:   aluOp = ALUOP_LUI;
                endcase
                aluSrc  = 1'b1;
                writeEn = 1'b1;
            end
            `OP_ANDI, `OP_ORI, `OP_XORI: begin
                case (opcode)
                    `OP_ANDI: aluOp = ALUOP_ANDI;
                    `OP_ORI:  aluOp = ALUOP_ORI;
                    default:  aluOp = ALUOP_XORI;
                endcase
                aluSrc  = 1'b1;
                zeroExt = 1'b1;   // Logical immediates
                writeEn = 1'b1;
            end
            default: writeEn = 1'b0;
        endcase
    end

    // Kept apart from the decode so the moveOk return path is not a loop
    assign regWrite = writeEn & moveOk;

endmodule

// File: src/ALUControl.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module ALUControl (
    input  mips_pkg::aluOpE   aluOp,
    input  logic [5:0]        funct,
    output mips_pkg::aluCtrlE aluCtrl
);
    import mips_pkg::*;

    always_comb begin
        case (aluOp)
            ALUOP_ZERO: begin
                case (funct)
                    `FUNC_SLL:   aluCtrl = SLL;
                    `FUNC_SRA:   aluCtrl = SRA;
                    `FUNC_SLLV:  aluCtrl = SLLV;
                    `FUNC_SRAV:  aluCtrl = SRAV;
                    `FUNC_ADD:   aluCtrl = ADD;
                    `FUNC_ADDU:  aluCtrl = ADDU;
                    `FUNC_SUB:   aluCtrl = SUB;
                    `FUNC_AND:   aluCtrl = AND;
                    `FUNC_OR:    aluCtrl = OR;
                    `FUNC_XOR:   aluCtrl = XOR;
                    `FUNC_NOR:   aluCtrl = NOR;
                    `FUNC_SLT:   aluCtrl = SLT;
                    `FUNC_SLTU:  aluCtrl = SLTU;
                    `FUNC_MOVZ:  aluCtrl = MOVZ;
                    `FUNC_MOVN:  aluCtrl = MOVN;
                    `FUNC_MULT:  aluCtrl = MULT;
                    `FUNC_MULTU: aluCtrl = MULTU;
                    `FUNC_MTHI:  aluCtrl = MTHI;
                    `FUNC_MTLO:  aluCtrl = MTLO;
                    `FUNC_MFHI:  aluCtrl = MFHI;
                    `FUNC_MFLO:  aluCtrl = MFLO;
                    default:     aluCtrl = ADD;
                endcase
            end

            ALUOP_MUL: begin
                case (funct)
                    `FUNC_MUL:  aluCtrl = MUL;
                    `FUNC_MADD: aluCtrl = MADD;
                    `FUNC_MSUB: aluCtrl = MSUB;
                    default:    aluCtrl = ADD;
                endcase
            end

            ALUOP_ADDIU:    aluCtrl = ADDU;
            ALUOP_ADDI:     aluCtrl = ADD;
            ALUOP_LUI:      aluCtrl = LUI;
            ALUOP_BLTZ:     aluCtrl = BLTZ;
            ALUOP_BGEZ:     aluCtrl = BGEZ;
            ALUOP_BEQ:      aluCtrl = BEQ;
            ALUOP_BNE:      aluCtrl = BNE;
            ALUOP_BGTZ:     aluCtrl = BGTZ;
            ALUOP_BLEZ:     aluCtrl = BLEZ;
            ALUOP_JUMP:     aluCtrl = JUMP;
            ALUOP_ANDI:     aluCtrl = AND;
            ALUOP_ORI:      aluCtrl = OR;
            ALUOP_XORI:     aluCtrl = XOR;
            ALUOP_SEB:      aluCtrl = SEB;
            ALUOP_SEH:      aluCtrl = SEH;
            ALUOP_SLTI:     aluCtrl = SLT;
            ALUOP_SLTIU:    aluCtrl = SLTU;   // Sign-extended imm, unsigned compare
            ALUOP_SRL:      aluCtrl = SRL;
            ALUOP_SRLV:     aluCtrl = SRLV;
            ALUOP_ROTR:     aluCtrl = ROTR;
            ALUOP_ROTRV:    aluCtrl = ROTRV;
            ALUOP_SPECIAL3: aluCtrl = ADD;    // Nothing else lives there yet
            default:        aluCtrl = ADD;
        endcase
    end

endmodule

// File: src/ALU.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module ALU (
    input  mips_pkg::aluCtrlE aluCtrl,
    input  mips_pkg::wordT    a,
    input  mips_pkg::wordT    b,
    input  logic [4:0]        shamt,
    input  mips_pkg::wordT    hi,
    input  mips_pkg::wordT    lo,
    output mips_pkg::wordT    result,
    output logic              branchTaken,
    output logic              jump,
    output logic              moveOk
);
    import mips_pkg::*;

    logic aZero;
    logic aNeg;

    // Rotate right through a doubled word
    function automatic wordT rotr(input wordT value, input logic [4:0] amount);
        logic [2*`DATA_WIDTH-1:0] doubled;
        doubled = {value, value} >> amount;
        return doubled[`DATA_WIDTH-1:0];
    endfunction

    assign aZero = (a == '0);
    assign aNeg  = a[`DATA_WIDTH-1];

    always_comb begin
        case (aluCtrl)
            ADD, ADDU:  result = a + b;   // No overflow trap
            SUB:        result = a - b;
            MUL:        result = a * b;   // Low word is sign-agnostic
            AND:        result = a & b;
            OR:         result = a | b;
            XOR:        result = a ^ b;
            NOR:        result = ~(a | b);
            SLT:        result = wordT'($signed(a) < $signed(b));
            SLTU:       result = wordT'(a < b);
            LUI:        result = {b[15:0], 16'h0000};
            SLL:        result = b << shamt;
            SRL:        result = b >> shamt;
            SRA:        result = $signed(b) >>> shamt;
            ROTR:       result = rotr(b, shamt);
            SLLV:       result = b << a[4:0];
            SRLV:       result = b >> a[4:0];
            SRAV:       result = $signed(b) >>> a[4:0];
            ROTRV:      result = rotr(b, a[4:0]);
            SEB:        result = wordT'($signed(b[7:0]));
            SEH:        result = wordT'($signed(b[15:0]));
            MOVZ, MOVN: result = a;
            MFHI:       result = hi;
            MFLO:       result = lo;
            JUMP:       result = a;   // JR target
            default:    result = '0;
        endcase
    end

    always_comb begin
        case (aluCtrl)
            BEQ:     branchTaken = (a == b);
            BNE:     branchTaken = (a != b);
            BGTZ:    branchTaken = !aNeg && !aZero;
            BLEZ:    branchTaken = aNeg || aZero;
            BLTZ:    branchTaken = aNeg;
            BGEZ:    branchTaken = !aNeg;
            default: branchTaken = 1'b0;
        endcase
    end

    assign jump = (aluCtrl == JUMP);

    // High for every op except a conditional move that fails
    always_comb begin
        case (aluCtrl)
            MOVZ:    moveOk = (b == '0);
            MOVN:    moveOk = (b != '0);
            default: moveOk = 1'b1;
        endcase
    end

endmodule

// File: src/HiLoReg.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module HiLoReg (
    input  logic              clk,
    input  logic              rst,
    input  mips_pkg::aluCtrlE aluCtrl,
    input  mips_pkg::wordT    a,
    input  mips_pkg::wordT    b,
    output mips_pkg::wordT    hi,
    output mips_pkg::wordT    lo
);
    import mips_pkg::*;

    logic        [2*`DATA_WIDTH-1:0] acc;     // HI:LO
    logic signed [2*`DATA_WIDTH-1:0] sProd;
    logic        [2*`DATA_WIDTH-1:0] uProd;

    assign sProd = $signed(a) * $signed(b);   // Operands sign-extended to 64 bits
    assign uProd = {{`DATA_WIDTH{1'b0}}, a} * {{`DATA_WIDTH{1'b0}}, b};

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else begin
            case (aluCtrl)
                MULT:    acc <= sProd;
                MULTU:   acc <= uProd;
                MADD:    acc <= acc + sProd;
                MSUB:    acc <= acc - sProd;
                MTHI:    acc[2*`DATA_WIDTH-1:`DATA_WIDTH] <= a;
                MTLO:    acc[`DATA_WIDTH-1:0] <= a;
                default: acc <= acc;
            endcase
        end
    end

    assign hi = acc[2*`DATA_WIDTH-1:`DATA_WIDTH];
    assign lo = acc[`DATA_WIDTH-1:0];

endmodule

// File: src/ExecuteStage.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module ExecuteStage (
    input  logic           clk,
    input  logic           rst,
    input  logic [31:0]    instr,
    input  mips_pkg::wordT rsData,
    input  mips_pkg::wordT rtData,
    output mips_pkg::wordT result,
    output logic           branchTaken,
    output logic           jump,
    output logic           regWrite
);
    import mips_pkg::*;

    aluOpE   aluOp;
    aluCtrlE aluCtrl;
    logic    aluSrc;
    logic    zeroExt;
    logic    moveOk;
    wordT    extImm;
    wordT    opB;     // Second ALU operand
    wordT    hi;
    wordT    lo;

    // 16-bit immediate widened to a word
    assign extImm = zeroExt ? {{(`DATA_WIDTH-16){1'b0}}, instr[15:0]}
                            : {{(`DATA_WIDTH-16){instr[15]}}, instr[15:0]};
    assign opB    = aluSrc ? extImm : rtData;

    Controller i_Controller (
        .instr    (instr),
        .aluOp    (aluOp),
        .aluSrc   (aluSrc),
        .zeroExt  (zeroExt),
        .regWrite (regWrite),
        .moveOk   (moveOk)
    );

    ALUControl i_ALUControl (
        .aluOp   (aluOp),
        .funct   (instr[5:0]),
        .aluCtrl (aluCtrl)
    );

    ALU i_ALU (
        .aluCtrl     (aluCtrl),
        .a           (rsData),
        .b           (opB),
        .shamt       (instr[10:6]),
        .hi          (hi),
        .lo          (lo),
        .result      (result),
        .branchTaken (branchTaken),
        .jump        (jump),
        .moveOk      (moveOk)
    );

    // HI/LO ops are register format, so rtData is the second operand
    HiLoReg i_HiLoReg (
        .clk     (clk),
        .rst     (rst),
        .aluCtrl (aluCtrl),
        .a       (rsData),
        .b       (rtData),
        .hi      (hi),
        .lo      (lo)
    );

endmodule

// File: sim/tb_ExecuteStage.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module tb_ExecuteStage;
    import mips_pkg::*;

    localparam int ResetCycles = 10;
    localparam int PerGroup    = 150;   // Random instructions per group
    localparam int NumGroups   = 6;
    localparam int NumInstr    = PerGroup * NumGroups + 2;
    localparam int WatchdogNs  = (ResetCycles + NumInstr) * 10 + 2000;

    localparam int GrpAlu    = 0;
    localparam int GrpImm    = 1;
    localparam int GrpShift  = 2;
    localparam int GrpMul    = 3;
    localparam int GrpBranch = 4;
    localparam int GrpMisc   = 5;   // Conditional moves and undefined encodings

    localparam logic [10:0][5:0] AluFuncts = {`FUNC_ADD, `FUNC_ADDU, `FUNC_SUB, `FUNC_AND,
        `FUNC_OR, `FUNC_XOR, `FUNC_NOR, `FUNC_SLT, `FUNC_SLTU, `FUNC_MOVZ, `FUNC_MOVN};
    localparam logic [7:0][5:0] ImmOps = {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
        `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] instr;
    wordT        rsData;
    wordT        rtData;
    wordT        result;
    logic        branchTaken;
    logic        jump;
    logic        regWrite;

    logic [31:0] lfsr = 32'h25df;
    logic [63:0] shadowAcc = '0;   // HI:LO as the testbench sees it
    logic [34:0] expected;         // {result, branchTaken, jump, regWrite}

    ExecuteStage i_ExecuteStage (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .rsData      (rsData),
        .rtData      (rtData),
        .result      (result),
        .branchTaken (branchTaken),
        .jump        (jump),
        .regWrite    (regWrite)
    );

    always #5 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic wordT pickOperand();
        logic [31:0] bits;
        bits = randBits(3);
        case (bits[2:0])
            3'd0:    return '0;
            3'd1:    return 32'h8000_0000;
            3'd2:    return 32'hffff_ffff;
            default: return randBits(32);
        endcase
    endfunction

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
        return {`OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT rotRight(input wordT v, input logic [4:0] n);
        return (v >> n) | (v << (6'd32 - n));   // Shift by 32 gives zero for n = 0
    endfunction

    function automatic logic [63:0] signedProduct(input wordT x, input wordT y);
        return {{32{x[31]}}, x} * {{32{y[31]}}, y};
    endfunction

    function automatic logic [31:0] makeInstr(input int group);
        logic [31:0] bits;
        logic [31:0] ext;
        logic [4:0]  rsF;
        logic [4:0]  rtF;
        logic [4:0]  rdF;
        logic [4:0]  sa;
        logic [3:0]  pick;
        logic [31:0] ins;
        bits = randBits(24);
        ext  = randBits(26);   // Immediate or jump target
        rsF  = bits[4:0];
        rtF  = bits[9:5];
        rdF  = bits[14:10];
        sa   = bits[19:15];
        pick = bits[23:20];
        case (group)
            GrpAlu: ins = rType(rsF, rtF, rdF, 5'd0, AluFuncts[pick % 11]);
            GrpImm: ins = iType(ImmOps[pick % 8], rsF, rtF, ext[15:0]);
            GrpShift: begin
                case (pick % 10)
                    0:       ins = rType(5'd0, rtF, rdF, sa, `FUNC_SLL);
                    1:       ins = rType(5'd0, rtF, rdF, sa, `FUNC_SRL);
                    2:       ins = rType(5'd1, rtF, rdF, sa, `FUNC_SRL);   // ROTR
                    3:       ins = rType(5'd0, rtF, rdF, sa, `FUNC_SRA);
                    4:       ins = rType(rsF, rtF, rdF, 5'd0, `FUNC_SLLV);
                    5:       ins = rType(rsF, rtF, rdF, 5'd0, `FUNC_SRLV);
                    6:       ins = rType(rsF, rtF, rdF, 5'd1, `FUNC_SRLV);  // ROTRV
                    7:       ins = rType(rsF, rtF, rdF, 5'd0, `FUNC_SRAV);
                    8:       ins = {`OP_SPECIAL3, 5'd0, rtF, rdF, `SA_SEB, `FUNC_SEB};
                    default: ins = {`OP_SPECIAL3, 5'd0, rtF, rdF, `SA_SEH, `FUNC_SEB};
                endcase
            end
            GrpMul: begin
                case (pick % 9)
                    0:       ins = rType(rsF, rtF, 5'd0, 5'd0, `FUNC_MULT);
                    1:       ins = rType(rsF, rtF, 5'd0, 5'd0, `FUNC_MULTU);
                    2:       ins = {`OP_SPECIAL2, rsF, rtF, 10'd0, `FUNC_MADD};
                    3:       ins = {`OP_SPECIAL2, rsF, rtF, 10'd0, `FUNC_MSUB};
                    4:       ins = rType(rsF, 5'd0, 5'd0, 5'd0, `FUNC_MTHI);
                    5:       ins = rType(rsF, 5'd0, 5'd0, 5'd0, `FUNC_MTLO);
                    6:       ins = rType(5'd0, 5'd0, rdF, 5'd0, `FUNC_MFHI);
                    7:       ins = rType(5'd0, 5'd0, rdF, 5'd0, `FUNC_MFLO);
                    default: ins = {`OP_SPECIAL2, rsF, rtF, rdF, 5'd0, `FUNC_MUL};
                endcase
            end
            GrpBranch: begin
                case (pick % 9)
                    0:       ins = iType(`OP_BEQ, rsF, rtF, ext[15:0]);
                    1:       ins = iType(`OP_BNE, rsF, rtF, ext[15:0]);
                    2:       ins = iType(`OP_BGTZ, rsF, 5'd0, ext[15:0]);
                    3:       ins = iType(`OP_BLEZ, rsF, 5'd0, ext[15:0]);
                    4:       ins = iType(`OP_REGIMM, rsF, `RT_BLTZ, ext[15:0]);
                    5:       ins = iType(`OP_REGIMM, rsF, `RT_BGEZ, ext[15:0]);
                    6:       ins = {`OP_J, ext[25:0]};
                    7:       ins = {`OP_JAL, ext[25:0]};
                    default: ins = rType(rsF, 5'd0, 5'd0, 5'd0, `FUNC_JR);
                endcase
            end
            default: begin
                case (pick % 8)
                    0, 1:    ins = rType(rsF, rtF, rdF, 5'd0, `FUNC_MOVZ);
                    2, 3:    ins = rType(rsF, rtF, rdF, 5'd0, `FUNC_MOVN);
                    4:       ins = rType(rsF, rtF, rdF, 5'd0, 6'b000001);   // No such funct
                    5:       ins = iType(6'b110001, rsF, rtF, ext[15:0]);    // No such opcode
                    6:       ins = {`OP_SPECIAL2, rsF, rtF, rdF, 5'd0, 6'b111111};
                    default: ins = {`OP_SPECIAL3, 5'd0, rtF, rdF, 5'd0, `FUNC_SEB};
                endcase
            end
        endcase
        return ins;
    endfunction

    // Expected outputs from the decoding rules
    function automatic logic [34:0] refModel(input logic [31:0] ins, input wordT rs,
                                             input wordT rt, input wordT hiV, input wordT loV);
        logic [5:0]  fn;
        logic [4:0]  sa;
        wordT        sImm;
        wordT        zImm;
        wordT        res;
        logic [63:0] prod;
        logic        br;
        logic        jmp;
        logic        wr;
        fn   = ins[5:0];
        sa   = ins[10:6];
        sImm = {{16{ins[15]}}, ins[15:0]};
        zImm = {16'h0000, ins[15:0]};
        prod = signedProduct(rs, rt);
        res  = rs + rt;   // Unknown encodings act as ADD without a write
        br   = 1'b0;
        jmp  = 1'b0;
        wr   = 1'b0;
        case (ins[31:26])
            `OP_SPECIAL: begin
                wr = 1'b1;
                case (fn)
                    `FUNC_ADD, `FUNC_ADDU: res = rs + rt;
                    `FUNC_SUB:  res = rs - rt;
                    `FUNC_AND:  res = rs & rt;
                    `FUNC_OR:   res = rs | rt;
                    `FUNC_XOR:  res = rs ^ rt;
                    `FUNC_NOR:  res = ~(rs | rt);
                    `FUNC_SLT:  res = {31'd0, $signed(rs) < $signed(rt)};
                    `FUNC_SLTU: res = {31'd0, rs < rt};
                    `FUNC_SLL:  res = rt << sa;
                    `FUNC_SRL:  res = ins[21] ? rotRight(rt, sa) : rt >> sa;
                    `FUNC_SRA:  res = $signed(rt) >>> sa;
                    `FUNC_SLLV: res = rt << rs[4:0];
                    `FUNC_SRLV: res = ins[6] ? rotRight(rt, rs[4:0]) : rt >> rs[4:0];
                    `FUNC_SRAV: res = $signed(rt) >>> rs[4:0];
                    `FUNC_MOVZ: begin
                        res = rs;
                        wr  = (rt == '0);
                    end
                    `FUNC_MOVN: begin
                        res = rs;
                        wr  = (rt != '0);
                    end
                    `FUNC_MFHI: res = hiV;
                    `FUNC_MFLO: res = loV;
                    `FUNC_MULT, `FUNC_MULTU, `FUNC_MTHI, `FUNC_MTLO: begin
                        res = '0;
                        wr  = 1'b0;
                    end
                    `FUNC_JR: begin
                        res = rs;   // Jump target
                        jmp = 1'b1;
                        wr  = 1'b0;
                    end
                    default: wr = 1'b0;
                endcase
            end
            `OP_SPECIAL2: begin
                if (fn == `FUNC_MUL) begin
                    res = prod[31:0];
                    wr  = 1'b1;
                end else if (fn == `FUNC_MADD || fn == `FUNC_MSUB) begin
                    res = '0;
                end
            end
            `OP_SPECIAL3: begin
                if (fn == `FUNC_SEB && sa == `SA_SEB) begin
                    res = {{24{rt[7]}}, rt[7:0]};
                    wr  = 1'b1;
                end else if (fn == `FUNC_SEB && sa == `SA_SEH) begin
                    res = {{16{rt[15]}}, rt[15:0]};
                    wr  = 1'b1;
                end
            end
            `OP_REGIMM: begin
                if (ins[20:16] == `RT_BLTZ || ins[20:16] == `RT_BGEZ) begin
                    res = '0;
                    br  = (ins[20:16] == `RT_BLTZ) ? rs[31] : !rs[31];
                end
            end
            `OP_J, `OP_JAL: begin
                res = rs;
                jmp = 1'b1;
                wr  = (ins[31:26] == `OP_JAL);   // Link write
            end
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: begin
                res = '0;
                case (ins[31:26])
                    `OP_BEQ:  br = (rs == rt);
                    `OP_BNE:  br = (rs != rt);
                    `OP_BLEZ: br = rs[31] || (rs == '0);
                    default:  br = !rs[31] && (rs != '0);
                endcase
            end
            `OP_ADDI, `OP_ADDIU: begin
                res = rs + sImm;
                wr  = 1'b1;
            end
            `OP_SLTI: begin
                res = {31'd0, $signed(rs) < $signed(sImm)};
                wr  = 1'b1;
            end
            `OP_SLTIU: begin
                res = {31'd0, rs < sImm};
                wr  = 1'b1;
            end
            `OP_ANDI, `OP_ORI, `OP_XORI: begin
                case (ins[31:26])
                    `OP_ANDI: res = rs & zImm;
                    `OP_ORI:  res = rs | zImm;
                    default:  res = rs ^ zImm;
                endcase
                wr = 1'b1;
            end
            `OP_LUI: begin
                res = {ins[15:0], 16'h0000};
                wr  = 1'b1;
            end
            default: wr = 1'b0;
        endcase
        return {res, br, jmp, wr};
    endfunction

    // Next HI:LO after the instruction retires
    function automatic logic [63:0] hiloNext(input logic [31:0] ins, input wordT rs,
                                             input wordT rt, input logic [63:0] acc);
        logic [63:0] next;
        next = acc;
        if (ins[31:26] == `OP_SPECIAL) begin
            case (ins[5:0])
                `FUNC_MULT:  next = signedProduct(rs, rt);
                `FUNC_MULTU: next = {32'd0, rs} * {32'd0, rt};
                `FUNC_MTHI:  next = {rs, acc[31:0]};
                `FUNC_MTLO:  next = {acc[63:32], rs};
                default:     next = acc;
            endcase
        end else if (ins[31:26] == `OP_SPECIAL2 && ins[5:0] == `FUNC_MADD) begin
            next = acc + signedProduct(rs, rt);
        end else if (ins[31:26] == `OP_SPECIAL2 && ins[5:0] == `FUNC_MSUB) begin
            next = acc - signedProduct(rs, rt);
        end
        return next;
    endfunction

    task automatic checkWord(input string name, input wordT actual, input wordT exp);
        if (actual !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h (instr 0x%08h)",
                     name, actual, exp, instr);
            $display("Simulation FAILED");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic exp);
        if (actual !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h (instr 0x%08h)",
                     name, actual, exp, instr);
            $display("Simulation FAILED");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic issue(input logic [31:0] ins, input wordT rs, input wordT rt);
        @(posedge clk);
        instr  <= ins;
        rsData <= rs;
        rtData <= rt;
    endtask

    task automatic runGroup(input int group);
        logic [31:0] ins;
        logic [31:0] bits;
        wordT        rs;
        wordT        rt;
        for (int n = 0; n < PerGroup; n++) begin
            ins  = makeInstr(group);
            rs   = pickOperand();
            rt   = pickOperand();
            bits = randBits(2);
            if (bits[1:0] == 2'd0) begin
                rt = (group == GrpBranch) ? rs : '0;   // Equal or zero operands
            end
            issue(ins, rs, rt);
        end
    endtask

    // Shadow follows the DUT registers on the same edge
    always @(posedge clk) begin
        if (rst) begin
            shadowAcc = '0;
        end else begin
            shadowAcc = hiloNext(instr, rsData, rtData, shadowAcc);
        end
    end

    // Outputs are settled half a cycle after the inputs change
    always @(negedge clk) begin
        if (!rst) begin
            expected = refModel(instr, rsData, rtData, shadowAcc[63:32], shadowAcc[31:0]);
            checkWord("result", result, expected[34:3]);
            checkFlag("branchTaken", branchTaken, expected[2]);
            checkFlag("jump", jump, expected[1]);
            checkFlag("regWrite", regWrite, expected[0]);
        end
    end

    initial begin
        #(WatchdogNs * 1ns);
        $display("Timeout: %0d planned instructions did not complete", NumInstr);
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rst    = 1'b1;
        instr  = '0;
        rsData = '0;
        rtData = '0;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        issue(rType(5'd0, 5'd0, 5'd2, 5'd0, `FUNC_MFHI), randBits(32), randBits(32));
        issue(rType(5'd0, 5'd0, 5'd3, 5'd0, `FUNC_MFLO), randBits(32), randBits(32));
        for (int g = GrpAlu; g <= GrpMisc; g++) begin
            runGroup(g);
        end
        @(posedge clk);
        @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: all.f
+incdir+src
src/mips_pkg.sv
src/Controller.sv
src/ALUControl.sv
src/ALU.sv
src/HiLoReg.sv
src/ExecuteStage.sv
sim/tb_ExecuteStage.sv

// File: Bender.yml
package:
  name: mips_execute

sources:
  - include_dirs:
      - src
    files:
      - src/mips_pkg.sv
      - src/Controller.sv
      - src/ALUControl.sv
      - src/ALU.sv
      - src/HiLoReg.sv
      - src/ExecuteStage.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/tb_ExecuteStage.sv
